//--- core_cfg.svh
// Build-time sizes of the core, shared by the package and the RTL.
// Include it wherever a width or a memory depth is needed.
`ifndef CORE_CFG_SVH
`define CORE_CFG_SVH

// data and instruction word width
`define WORD_BITS  32

// architectural registers, x0 included
`define REG_COUNT  32

// instruction memory words, sets the pc width
`define IMEM_DEPTH 64

`endif

//--- core.sv
// Types shared by all stages of the core: data words, register and pc
// indices, ALU operations, instruction field views and stage packets.
`include "core_cfg.svh"

package core;

    typedef logic [`WORD_BITS-1:0]          word_t;
    typedef logic [$clog2(`REG_COUNT)-1:0]  addr_t;
    typedef logic [$clog2(`IMEM_DEPTH)-1:0] pc_t;   // word index, not bytes

    typedef enum logic [6:0] {
        OPC_OP     = 7'b0110011, // register-register alu
        OPC_OPIMM  = 7'b0010011, // alu with 12-bit immediate
        OPC_LUI    = 7'b0110111,
        OPC_BRANCH = 7'b1100011, // beq, bne
        OPC_JAL    = 7'b1101111
    } opcode_t;

    typedef enum logic [3:0] {
        OP_ADD,
        OP_SUB,
        OP_AND,
        OP_OR,
        OP_XOR,
        OP_SLT,
        OP_SLL,
        OP_SRL,
        OP_PASS_B    // lui and jal, b goes straight through
    } op_t;

    typedef enum logic [1:0] {
        BR_NONE,
        BR_EQ,
        BR_NE,
        BR_JAL
    } br_t;

    // one instruction word, read by field layout
    typedef union packed {
        struct packed {
            logic [6:0] funct7;
            addr_t      rs2;
            addr_t      rs1;
            logic [2:0] funct3;
            addr_t      rd;
            opcode_t    opcode;
        } r;
        struct packed {
            logic [11:0] imm;
            addr_t       rs1;
            logic [2:0]  funct3;
            addr_t       rd;
            opcode_t     opcode;
        } i;
        struct packed {
            logic       imm_12;   // sign
            logic [5:0] imm_10_5;
            addr_t      rs2;
            addr_t      rs1;
            logic [2:0] funct3;
            logic [3:0] imm_4_1;
            logic       imm_11;
            opcode_t    opcode;
        } b;
        struct packed {
            logic       imm_20;   // sign
            logic [9:0] imm_10_1;
            logic       imm_11;
            logic [7:0] imm_19_12;
            addr_t      rd;
            opcode_t    opcode;
        } j;
        struct packed {
            logic [19:0] imm;     // upper 20 bits of the word
            addr_t       rd;
            opcode_t     opcode;
        } u;
    } inst_t;

    typedef struct packed {
        pc_t   pc;
        inst_t inst;
    } id_t;

    typedef struct packed {
        pc_t   pc;
        addr_t rd;      // zero when we is low
        op_t   op;
        word_t a;
        word_t b;
        br_t   br;
        pc_t   offset;  // branch or jump distance in words
        logic  we;
    } ex_t;

    typedef struct packed {
        pc_t   pc;
        addr_t rd;
        logic  we;
        word_t data;    // zero for records that write nothing
    } wb_t;

endpackage

//--- stream_if.sv
// Valid/ready stream between two pipeline stages, one packet per beat.
// A beat moves on a clock edge with valid and ready both high.
`timescale 1ns/1ps

interface stream_if #(
    parameter int WIDTH = 32
);
    logic             valid;
    logic             ready;
    logic [WIDTH-1:0] data;   // held steady while valid and not ready

    modport source (
        output valid,
        output data,
        input  ready
    );

    modport sink (
        input  valid,
        input  data,
        output ready
    );

    modport monitor (    // observe only, e.g. for bypass
        input valid,
        input ready,
        input data
    );
endinterface

//--- fetch.sv
// Fetch stage. Holds the instruction memory, loaded through the program
// port during reset, and streams pc and instruction words to decode.
`timescale 1ns/1ps
`include "core_cfg.svh"

module fetch
    import core::*;
(
    input  logic     clk,
    input  logic     arst_n,
    input  logic     prog_we,
    input  pc_t      prog_addr,
    input  word_t    prog_data,
    input  logic     branch,
    input  pc_t      target,
    stream_if.source sink
);
    word_t imem [`IMEM_DEPTH];
    pc_t   pc;      // next word to fetch
    logic  valid;
    id_t   id;
    logic  load;

    // program port only open while the core is held in reset
    always_ff @(posedge clk) begin
        if (!arst_n && prog_we) begin
            imem[prog_addr] <= prog_data;
        end
    end

    assign load = ~valid | sink.ready; // output empty or taken this edge

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            pc    <= '0;
            valid <= 1'b0;
        end else if (branch) begin
            pc    <= target;   // redirect
            valid <= 1'b0;     // wrong-path word never leaves
        end else if (load) begin
            pc    <= pc + 1'b1;
            valid <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (load) begin
            id.pc   <= pc;
            id.inst <= imem[pc];
        end
    end

    assign sink.valid = valid;
    assign sink.data  = id;
endmodule

//--- regfile.sv
// Register file, 32 words with x0 fixed at zero. Two combinational read
// ports see a write in the same cycle.
`timescale 1ns/1ps
`include "core_cfg.svh"

module regfile
    import core::*;
(
    input  logic  clk,
    input  addr_t rs1_addr,
    input  addr_t rs2_addr,
    output word_t rs1_data,
    output word_t rs2_data,
    input  logic  rd_en,
    input  addr_t rd_addr,
    input  word_t rd_data
);
    word_t regs [`REG_COUNT];

    function automatic word_t read_port(addr_t addr);
        if (addr == '0) begin
            return '0;
        end
        if (rd_en && rd_addr == addr) begin
            return rd_data;   // write-through
        end
        return regs[addr];
    endfunction

    always_comb begin
        rs1_data = read_port(rs1_addr);
        rs2_data = read_port(rs2_addr);
    end

    always_ff @(posedge clk) begin
        if (rd_en && rd_addr != '0) begin   // x0 drops writes
            regs[rd_addr] <= rd_data;
        end
    end
endmodule

//--- decode.sv
// Decode stage. Splits the instruction into fields, builds the immediate,
// picks forwarded or register operands and registers the execute packet.
`timescale 1ns/1ps

module decode
    import core::*;
(
    input  logic      clk,
    input  logic      arst_n,
    input  logic      branch,
    input  word_t     alu_data,
    output addr_t     rs1_addr,
    output addr_t     rs2_addr,
    input  word_t     rs1_data,
    input  word_t     rs2_data,
    stream_if.sink    source,
    stream_if.monitor wb_mon,
    stream_if.source  sink
);
    id_t   id;
    inst_t inst;
    wb_t   wb;
    logic  wb_valid;
    ex_t   ex_d;
    ex_t   ex_q;
    logic  ex_valid;
    word_t imm_i;
    word_t imm_b;
    word_t imm_j;
    word_t imm_u;
    word_t rs1_val;
    word_t rs2_val;

    assign id       = id_t'(source.data);
    assign inst     = id.inst;
    assign wb       = wb_t'(wb_mon.data);
    assign wb_valid = wb_mon.valid;

    assign rs1_addr = inst.r.rs1;   // same bit positions in every format
    assign rs2_addr = inst.r.rs2;

    // sign always from bit 31
    assign imm_i = {{20{inst.i.imm[11]}}, inst.i.imm};
    assign imm_b = {{20{inst.b.imm_12}}, inst.b.imm_11, inst.b.imm_10_5,
                    inst.b.imm_4_1, 1'b0};
    assign imm_j = {{12{inst.j.imm_20}}, inst.j.imm_19_12, inst.j.imm_11,
                    inst.j.imm_10_1, 1'b0};
    assign imm_u = {inst.u.imm, 12'b0};

    // youngest producer wins, we is never set for x0
    function automatic word_t pick_operand(addr_t rs, word_t rf_data);
        if (ex_valid && ex_q.we && ex_q.rd == rs) begin
            return alu_data;    // still in execute
        end
        if (wb_valid && wb.we && wb.rd == rs) begin
            return wb.data;     // leaving writeback
        end
        return rf_data;
    endfunction

    always_comb begin
        rs1_val = pick_operand(rs1_addr, rs1_data);
        rs2_val = pick_operand(rs2_addr, rs2_data);
    end

    always_comb begin
        ex_d.pc     = id.pc;
        ex_d.rd     = inst.r.rd;
        ex_d.op     = OP_PASS_B;
        ex_d.a      = rs1_val;
        ex_d.b      = rs2_val;
        ex_d.br     = BR_NONE;
        ex_d.offset = pc_t'(imm_b >> 2);   // bytes to words
        ex_d.we     = 1'b0;
        case (inst.r.opcode)
            OPC_OP: begin
                ex_d.we = (inst.r.funct7 == 7'b0000000) ||
                          (inst.r.funct7 == 7'b0100000 && inst.r.funct3 == 3'b000);
                case (inst.r.funct3)
                    3'b000:  ex_d.op = inst.r.funct7[5] ? OP_SUB : OP_ADD;
                    3'b001:  ex_d.op = OP_SLL;
                    3'b010:  ex_d.op = OP_SLT;
                    3'b100:  ex_d.op = OP_XOR;
                    3'b101:  ex_d.op = OP_SRL;
                    3'b110:  ex_d.op = OP_OR;
                    3'b111:  ex_d.op = OP_AND;
                    default: ex_d.we = 1'b0;   // sltu
                endcase
            end
            OPC_OPIMM: begin
                ex_d.b  = imm_i;
                ex_d.we = 1'b1;
                case (inst.i.funct3)
                    3'b000:  ex_d.op = OP_ADD;
                    3'b010:  ex_d.op = OP_SLT;
                    3'b100:  ex_d.op = OP_XOR;
                    3'b110:  ex_d.op = OP_OR;
                    3'b111:  ex_d.op = OP_AND;
                    default: ex_d.we = 1'b0;   // shift immediates, sltiu
                endcase
            end
            OPC_LUI: begin
                ex_d.b  = imm_u;
                ex_d.we = 1'b1;
            end
            OPC_BRANCH: begin
                case (inst.b.funct3)
                    3'b000:  ex_d.br = BR_EQ;
                    3'b001:  ex_d.br = BR_NE;
                    default: ex_d.br = BR_NONE; // other compares fall through
                endcase
            end
            OPC_JAL: begin
                ex_d.br     = BR_JAL;
                ex_d.offset = pc_t'(imm_j >> 2);
                ex_d.we     = 1'b1;            // link value
            end
            default: ex_d.we = 1'b0;           // outside the subset
        endcase
        if (ex_d.rd == '0) begin
            ex_d.we = 1'b0;
        end
        if (!ex_d.we) begin
            ex_d.rd = '0;   // non-writing records report rd zero
        end
    end

    assign source.ready = ~ex_valid | sink.ready;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            ex_valid <= 1'b0;
        end else if (branch) begin
            ex_valid <= 1'b0;       // younger packet squashed
        end else if (source.ready) begin
            ex_valid <= source.valid;
        end
    end

    always_ff @(posedge clk) begin
        if (source.valid && source.ready) begin
            ex_q <= ex_d;
        end
    end

    assign sink.valid = ex_valid;
    assign sink.data  = ex_q;
endmodule

//--- execute.sv
// Execute stage. Runs the ALU, resolves BEQ, BNE and JAL and redirects
// fetch on a taken one. The result also feeds back to decode as a bypass.
`timescale 1ns/1ps

module execute
    import core::*;
(
    input  logic     clk,
    input  logic     arst_n,
    output logic     branch,
    output pc_t      target,
    output word_t    alu_data,
    stream_if.sink   source,
    stream_if.source sink
);
    ex_t   ex;
    wb_t   wb_d;
    wb_t   wb_q;
    logic  wb_valid;
    logic  taken;
    word_t result;
    word_t link;

    assign ex = ex_t'(source.data);
    assign source.ready = ~wb_valid | sink.ready;

    always_comb begin
        case (ex.op)
            OP_ADD:  result = ex.a + ex.b;
            OP_SUB:  result = ex.a - ex.b;
            OP_AND:  result = ex.a & ex.b;
            OP_OR:   result = ex.a | ex.b;
            OP_XOR:  result = ex.a ^ ex.b;
            OP_SLT:  result = word_t'($signed(ex.a) < $signed(ex.b));
            OP_SLL:  result = ex.a << ex.b[4:0];
            OP_SRL:  result = ex.a >> ex.b[4:0];
            default: result = ex.b;    // pass b
        endcase
    end

    // byte address of the next word
    assign link     = (word_t'(ex.pc) + word_t'(1)) << 2;
    assign alu_data = (ex.br == BR_JAL) ? link : result;

    always_comb begin
        case (ex.br)
            BR_EQ:   taken = (ex.a == ex.b);
            BR_NE:   taken = (ex.a != ex.b);
            BR_JAL:  taken = 1'b1;
            default: taken = 1'b0;
        endcase
    end

    // one pulse as the branch moves on, next cycle has no valid input
    assign branch = source.valid & source.ready & taken;
    assign target = ex.pc + ex.offset;

    always_comb begin
        wb_d.pc   = ex.pc;
        wb_d.rd   = ex.rd;
        wb_d.we   = ex.we;
        wb_d.data = ex.we ? alu_data : '0;
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            wb_valid <= 1'b0;
        end else if (source.ready) begin
            wb_valid <= source.valid;
        end
    end

    always_ff @(posedge clk) begin
        if (source.valid && source.ready) begin
            wb_q <= wb_d;
        end
    end

    assign sink.valid = wb_valid;
    assign sink.data  = wb_q;
endmodule

//--- writeback.sv
// Writeback stage. Always ready; each accepted packet becomes a register
// write plus a retire record, and bumps the retire counter.
`timescale 1ns/1ps

module writeback
    import core::*;
(
    input  logic   clk,
    input  logic   arst_n,
    stream_if.sink source,
    output logic   rd_en,
    output addr_t  rd_addr,
    output word_t  rd_data,
    output logic   retire_valid,
    output pc_t    retire_pc,
    output addr_t  retire_rd,
    output logic   retire_we,
    output word_t  retire_data,
    output word_t  retire_count
);
    wb_t wb;

    assign wb           = wb_t'(source.data);
    assign source.ready = 1'b1;           // never back-pressures
    assign retire_valid = source.valid & source.ready;

    assign rd_en   = retire_valid & wb.we;
    assign rd_addr = wb.rd;
    assign rd_data = wb.data;

    assign retire_pc   = wb.pc;
    assign retire_rd   = wb.rd;
    assign retire_we   = wb.we;
    assign retire_data = wb.data;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            retire_count <= '0;
        end else if (retire_valid) begin
            retire_count <= retire_count + 1'b1;   // instructions retired so far
        end
    end
endmodule

//--- cpu.sv
// Top level of the core. Fetch, decode, execute and writeback pass packets
// over valid/ready streams; one retire record comes out per instruction.
`timescale 1ns/1ps

module cpu
    import core::*;
(
    input  logic  clk,
    input  logic  arst_n,
    input  logic  prog_we,
    input  pc_t   prog_addr,
    input  word_t prog_data,
    output logic  retire_valid,
    output pc_t   retire_pc,
    output addr_t retire_rd,
    output logic  retire_we,
    output word_t retire_data,
    output word_t retire_count
);
    stream_if #(.WIDTH($bits(id_t))) id ();   // fetch to decode
    stream_if #(.WIDTH($bits(ex_t))) ex ();   // decode to execute
    stream_if #(.WIDTH($bits(wb_t))) wb ();   // execute to writeback

    logic  branch;     // taken branch or jal, from execute
    pc_t   target;
    word_t alu_data;   // execute bypass
    addr_t rs1_addr;
    addr_t rs2_addr;
    word_t rs1_data;
    word_t rs2_data;
    logic  rd_en;
    addr_t rd_addr;
    word_t rd_data;

    fetch fetch (
        .*,
        .sink(id)
    );

    regfile regfile (.*);

    decode decode (
        .*,
        .source(id),
        .wb_mon(wb),    // second bypass taps the writeback stream
        .sink(ex)
    );

    execute execute (
        .*,
        .source(ex),
        .sink(wb)
    );

    writeback writeback (
        .*,
        .source(wb)
    );
endmodule

//--- clock_gen.sv
// Testbench clock and reset. Reset goes low at once while hold is high and
// comes back 4 clock edges after hold drops, so programs load under reset.
`timescale 1ns/1ps

module clock_gen #(
    parameter int PERIOD_NS    = 10,
    parameter int RESET_CYCLES = 4
) (
    input  logic hold,     // driven by the testbench during program load
    output logic clk,
    output logic arst_n
);
    int count;   // edges since hold dropped, saturates

    initial begin
        clk = 1'b0;
        forever #(PERIOD_NS / 2) clk = ~clk;
    end

    always_ff @(posedge clk or posedge hold) begin
        if (hold) begin
            count <= 0;
        end else if (count < RESET_CYCLES) begin
            count <= count + 1;
        end
    end

    // async assert, release on an edge
    assign arst_n = !hold && (count >= RESET_CYCLES);
endmodule

//--- cpu_assertions.sv
// Concurrent checks on the core's streams, branch pulse and retire port.
// Bound into every cpu instance by the bind at the end of this file.
`timescale 1ns/1ps

module cpu_assertions
    import core::*;
(
    input logic  clk,
    input logic  arst_n,
    input logic  id_valid,
    input logic  id_ready,
    input id_t   id_data,
    input logic  ex_valid,
    input logic  ex_ready,
    input ex_t   ex_data,
    input logic  wb_valid,
    input logic  wb_ready,
    input wb_t   wb_data,
    input logic  branch,
    input logic  retire_valid,
    input logic  retire_we,
    input addr_t retire_rd
);
    int fail_count = 0;   // read by the testbench at the end

    // stalled beat keeps its payload
    id_hold: assert property (@(posedge clk) disable iff (!arst_n)
        id_valid && !id_ready |=> $stable(id_data))
    else begin
        $error("id stream data changed while stalled");
        fail_count++;
    end

    ex_hold: assert property (@(posedge clk) disable iff (!arst_n)
        ex_valid && !ex_ready |=> $stable(ex_data))
    else begin
        $error("ex stream data changed while stalled");
        fail_count++;
    end

    wb_hold: assert property (@(posedge clk) disable iff (!arst_n)
        wb_valid && !wb_ready |=> $stable(wb_data))
    else begin
        $error("wb stream data changed while stalled");
        fail_count++;
    end

    // redirect is a single-cycle pulse
    branch_pulse: assert property (@(posedge clk) disable iff (!arst_n)
        branch |=> !branch)
    else begin
        $error("branch high on two consecutive cycles");
        fail_count++;
    end

    no_x0_write: assert property (@(posedge clk) disable iff (!arst_n)
        retire_valid && retire_we |-> retire_rd != '0)
    else begin
        $error("retire reports a write to x0");
        fail_count++;
    end
endmodule

bind cpu cpu_assertions checks (
    .clk          (clk),
    .arst_n       (arst_n),
    .id_valid     (id.valid),
    .id_ready     (id.ready),
    .id_data      (id.data),
    .ex_valid     (ex.valid),
    .ex_ready     (ex.ready),
    .ex_data      (ex.data),
    .wb_valid     (wb.valid),
    .wb_ready     (wb.ready),
    .wb_data      (wb.data),
    .branch       (branch),
    .retire_valid (retire_valid),
    .retire_we    (retire_we),
    .retire_rd    (retire_rd)
);

//--- tb_cpu.sv
// Testbench for the core. Loads random programs through the program port
// under reset, runs an instruction-set model and checks every retire record.
`timescale 1ns/1ps
`include "core_cfg.svh"

module tb_cpu
    import core::*;
();
    localparam int PROG_LEN  = 40;
    localparam int HALT_PC   = PROG_LEN - 1;   // jal to itself
    localparam int NUM_TESTS = 6;
    localparam int TIMEOUT   = 500;

    typedef enum int {
        K_ADD, K_SUB, K_AND, K_OR, K_XOR, K_SLT, K_SLL, K_SRL,
        K_ADDI, K_ANDI, K_ORI, K_XORI, K_SLTI, K_LUI,
        K_BEQ, K_BNE, K_JAL, K_BAD
    } kind_t;

    logic  clk;
    logic  arst_n;
    logic  hold;
    logic  prog_we;
    pc_t   prog_addr;
    word_t prog_data;
    logic  retire_valid;
    pc_t   retire_pc;
    addr_t retire_rd;
    logic  retire_we;
    word_t retire_data;
    word_t retire_count;

    kind_t prog_kind [PROG_LEN];
    addr_t prog_rd   [PROG_LEN];
    addr_t prog_rs1  [PROG_LEN];
    addr_t prog_rs2  [PROG_LEN];
    int    prog_imm  [PROG_LEN];   // immediate, or distance in words
    word_t prog_word [PROG_LEN];

    pc_t   exp_pc   [$];   // model retire sequence
    addr_t exp_rd   [$];
    logic  exp_we   [$];
    word_t exp_data [$];

    int errors;
    int test_errors;

    clock_gen clocks (.hold(hold), .clk(clk), .arst_n(arst_n));

    cpu DUT (.*);

    function automatic word_t encode(int i);
        logic [12:0] b;
        logic [20:0] j;
        addr_t       rd;
        addr_t       r1;
        addr_t       r2;
        rd = prog_rd[i];
        r1 = prog_rs1[i];
        r2 = prog_rs2[i];
        b  = 13'(prog_imm[i] * 4);   // words to bytes
        j  = 21'(prog_imm[i] * 4);
        case (prog_kind[i])
            K_ADD:  return {7'h00, r2, r1, 3'b000, rd, 7'b0110011};
            K_SUB:  return {7'h20, r2, r1, 3'b000, rd, 7'b0110011};
            K_SLL:  return {7'h00, r2, r1, 3'b001, rd, 7'b0110011};
            K_SLT:  return {7'h00, r2, r1, 3'b010, rd, 7'b0110011};
            K_XOR:  return {7'h00, r2, r1, 3'b100, rd, 7'b0110011};
            K_SRL:  return {7'h00, r2, r1, 3'b101, rd, 7'b0110011};
            K_OR:   return {7'h00, r2, r1, 3'b110, rd, 7'b0110011};
            K_AND:  return {7'h00, r2, r1, 3'b111, rd, 7'b0110011};
            K_ADDI: return {12'(prog_imm[i]), r1, 3'b000, rd, 7'b0010011};
            K_SLTI: return {12'(prog_imm[i]), r1, 3'b010, rd, 7'b0010011};
            K_XORI: return {12'(prog_imm[i]), r1, 3'b100, rd, 7'b0010011};
            K_ORI:  return {12'(prog_imm[i]), r1, 3'b110, rd, 7'b0010011};
            K_ANDI: return {12'(prog_imm[i]), r1, 3'b111, rd, 7'b0010011};
            K_LUI:  return {20'(prog_imm[i]), rd, 7'b0110111};
            K_BEQ:  return {b[12], b[10:5], r2, r1, 3'b000, b[4:1], b[11], 7'b1100011};
            K_BNE:  return {b[12], b[10:5], r2, r1, 3'b001, b[4:1], b[11], 7'b1100011};
            K_JAL:  return {j[20], j[10:1], j[11], j[19:12], rd, 7'b1101111};
            default: return {25'(prog_imm[i]), 7'b0000000};   // opcode 0, not in subset
        endcase
    endfunction

    // chained: each source reads the last two destinations written
    task automatic gen_program(input bit chained);
        addr_t w1;
        addr_t w2;
        int    k;
        int    span;
        w1 = addr_t'(7);
        w2 = addr_t'(6);
        for (int i = 0; i < 7; i++) begin   // x1..x7 get known values
            prog_kind[i] = K_ADDI;
            prog_rd[i]   = addr_t'(i + 1);
            prog_rs1[i]  = '0;
            prog_rs2[i]  = '0;
            prog_imm[i]  = int'($urandom_range(4095)) - 2048;
        end
        for (int i = 7; i < HALT_PC; i++) begin
            k            = int'($urandom_range(19));
            prog_kind[i] = (k >= 18) ? K_ADDI : kind_t'(k);
            prog_rd[i]   = addr_t'($urandom_range(7));   // x0 included
            prog_rs1[i]  = chained ? w1 : addr_t'($urandom_range(7));
            prog_rs2[i]  = chained ? w2 : addr_t'($urandom_range(7));
            span         = (HALT_PC - i > 4) ? 4 : HALT_PC - i;   // forward only
            case (prog_kind[i])
                K_LUI:                      prog_imm[i] = int'($urandom_range(32'h000f_ffff));
                K_BEQ, K_BNE, K_JAL:        prog_imm[i] = int'($urandom_range(span, 1));
                K_BAD:                      prog_imm[i] = int'($urandom);
                default:                    prog_imm[i] = int'($urandom_range(4095)) - 2048;
            endcase
            if (prog_kind[i] < K_BEQ || prog_kind[i] == K_JAL) begin
                w2 = w1;
                w1 = prog_rd[i];
            end
        end
        prog_kind[HALT_PC] = K_JAL;
        prog_rd[HALT_PC]   = addr_t'($urandom_range(7));
        prog_rs1[HALT_PC]  = '0;
        prog_rs2[HALT_PC]  = '0;
        prog_imm[HALT_PC]  = 0;
        for (int i = 0; i < PROG_LEN; i++) begin
            prog_word[i] = encode(i);
        end
    endtask

    // instruction-set model, fills the expected retire queues
    task automatic run_model();
        word_t regs [`REG_COUNT];
        word_t a;
        word_t b;
        word_t imm;
        word_t res;
        logic  writes;
        int    pc;
        int    next;
        foreach (regs[r]) regs[r] = '0;
        exp_pc.delete();
        exp_rd.delete();
        exp_we.delete();
        exp_data.delete();
        pc = 0;
        while (pc <= HALT_PC) begin
            a      = regs[prog_rs1[pc]];
            b      = regs[prog_rs2[pc]];
            imm    = word_t'(prog_imm[pc]);
            next   = pc + 1;
            writes = 1'b1;
            res    = '0;
            case (prog_kind[pc])
                K_ADD:  res = a + b;
                K_SUB:  res = a - b;
                K_AND:  res = a & b;
                K_OR:   res = a | b;
                K_XOR:  res = a ^ b;
                K_SLT:  res = word_t'($signed(a) < $signed(b));
                K_SLL:  res = a << b[4:0];
                K_SRL:  res = a >> b[4:0];
                K_ADDI: res = a + imm;
                K_ANDI: res = a & imm;
                K_ORI:  res = a | imm;
                K_XORI: res = a ^ imm;
                K_SLTI: res = word_t'($signed(a) < $signed(imm));
                K_LUI:  res = imm << 12;
                K_BEQ: begin
                    writes = 1'b0;
                    if (a == b) next = pc + prog_imm[pc];
                end
                K_BNE: begin
                    writes = 1'b0;
                    if (a != b) next = pc + prog_imm[pc];
                end
                K_JAL: begin
                    res  = word_t'((pc + 1) * 4);   // link in bytes
                    next = pc + prog_imm[pc];
                end
                default: writes = 1'b0;
            endcase
            writes = writes && (prog_rd[pc] != '0);
            if (writes) regs[prog_rd[pc]] = res;
            exp_pc.push_back(pc_t'(pc));
            exp_rd.push_back(writes ? prog_rd[pc] : addr_t'(0));
            exp_we.push_back(writes);
            exp_data.push_back(writes ? res : word_t'(0));
            if (pc == HALT_PC) break;
            pc = next;
        end
    endtask

    task automatic abort_run(input string why);
        $display("timeout: %s after %0d cycles", why, TIMEOUT);
        $display("Errors found");
        $finish;
    endtask

    task automatic check_retire(input pc_t pc, input pc_t exp_p, input addr_t rd,
                                input addr_t exp_r, input logic we, input logic exp_w,
                                input word_t data, input word_t exp_d);
        if (pc !== exp_p || rd !== exp_r || we !== exp_w || data !== exp_d) begin
            $display("MISMATCH t=%0t retire got/exp pc %0d/%0d rd %0d/%0d we %0b/%0b data %h/%h",
                     $time, pc, exp_p, rd, exp_r, we, exp_w, data, exp_d);
            test_errors++;
        end
    endtask

    task automatic check_count(input word_t got, input word_t exp_n);
        if (got !== exp_n) begin
            $display("MISMATCH t=%0t retire_count got %0d expected %0d", $time, got, exp_n);
            test_errors++;
        end
    endtask

    task automatic check_flag(input logic got, input logic exp_v, input string what);
        if (got !== exp_v) begin
            $display("MISMATCH t=%0t %s got %b expected %b", $time, what, got, exp_v);
            test_errors++;
        end
    endtask

    // one word per cycle while reset is held
    task automatic load_program();
        @(posedge clk);
        hold <= 1'b1;
        for (int i = 0; i < PROG_LEN; i++) begin
            prog_we   <= 1'b1;
            prog_addr <= pc_t'(i);
            prog_data <= prog_word[i];
            @(posedge clk);
        end
        prog_we <= 1'b0;
        hold    <= 1'b0;   // reset lifts 4 edges later
    endtask

    task automatic wait_reset_release();
        int cycles;
        cycles = 0;
        @(negedge clk);
        while (!arst_n) begin
            check_flag(retire_valid, 1'b0, "retire_valid in reset");
            check_count(retire_count, '0);
            if (cycles == TIMEOUT) abort_run("reset never released");
            cycles++;
            @(negedge clk);
        end
        check_flag(retire_valid, 1'b0, "retire_valid after reset");   // first free cycle
        check_count(retire_count, '0);
    endtask

    task automatic wait_retire();
        int cycles;
        cycles = 0;
        @(negedge clk);
        while (!retire_valid) begin
            if (cycles == TIMEOUT) abort_run("no instruction retired");
            cycles++;
            @(negedge clk);
        end
    endtask

    task automatic compare_retires();
        for (int n = 0; n < exp_pc.size(); n++) begin
            wait_retire();
            check_retire(retire_pc, exp_pc[n], retire_rd, exp_rd[n],
                         retire_we, exp_we[n], retire_data, exp_data[n]);
            check_count(retire_count, word_t'(n));   // retired before this one
        end
        @(negedge clk);   // halt counted now
        check_count(retire_count, word_t'(exp_pc.size()));
    endtask

    initial begin
        hold      = 1'b1;
        prog_we   = 1'b0;
        prog_addr = '0;
        prog_data = '0;
        errors    = 0;
        void'($urandom(90));
        for (int t = 0; t < NUM_TESTS; t++) begin
            test_errors = 0;
            gen_program(t[0]);   // odd tests chain operands
            run_model();
            load_program();
            wait_reset_release();
            compare_retires();
            $display("test %0d %s: %0d retired, %0d errors", t,
                     t[0] ? "forwarding" : "random mix", exp_pc.size(), test_errors);
            errors += test_errors;
        end
        errors += DUT.checks.fail_count;
        $display("%0d tests run, %0d errors, %0d assertion failures", NUM_TESTS, errors,
                 DUT.checks.fail_count);
        if (errors == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end
endmodule

//--- sim.f
+incdir+.
core.sv
stream_if.sv
fetch.sv
regfile.sv
decode.sv
execute.sv
writeback.sv
cpu.sv
clock_gen.sv
cpu_assertions.sv
tb_cpu.sv

//--- Makefile
# Verilator build and run of the core testbench.
# make run builds if needed, runs and fails unless the log shows a pass.

VERILATOR ?= verilator
TOP       ?= tb_cpu
FLIST     ?= sim.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0
PASS_MSG  ?= No errors

SRCS := $(filter %.sv %.v,$(shell cat $(FLIST)))
HDRS := $(wildcard *.svh)
BIN  := $(BUILD_DIR)/V$(TOP)

.PHONY: all run check clean

all: run

# rebuilt only when a source, header or the file list changes
$(BIN): $(SRCS) $(HDRS) $(FLIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FLIST)

run: $(BIN)
	$(BIN) | tee $(LOG)
	@grep -qx '$(PASS_MSG)' $(LOG)

check:
	@grep -qx '$(PASS_MSG)' $(LOG) || (echo "simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
